/* Makefile */
# Verilator build and run for the axis control core
VERILATOR ?= verilator
TOP       := tb_qla
RTL_TOP   := qla_top
FILELIST  := build.f
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
hdl/qla_pkg.sv
hdl/reg_decode.sv
hdl/axis_regs.sv
hdl/safety_check.sv
hdl/read_mux.sv
hdl/qla_top.sv
verif/tb_qla.sv

/* hdl/axis_regs.sv */
// register file, DAC commands, feedback latches, amp_req and dout
// writes land one edge after the decode stage
// feedback is sampled every cycle with no qualifier
// a status write is also the fault clear, safety_check sees the same wr
`timescale 1ns/1ns
`default_nettype none

module axis_regs (
    input  wire logic                              sysclk,
    input  wire logic                              rst_n,
    input  qla_pkg::reg_wr_t                       wr,
    input  qla_pkg::cur_vec_t                      cur_fb,
    input  wire logic [qla_pkg::NUM_AXES-1:0]      fault,
    output qla_pkg::axis_state_t                   state,
    output qla_pkg::cur_vec_t                      cur_cmd,
    output logic [3:0]                             dout
);

    logic                          chan0_wr;   // any board channel write
    logic                          status_wr;
    logic                          dout_wr;
    logic [qla_pkg::NUM_AXES-1:0]  cmd_wr;     // per axis DAC write
    logic [qla_pkg::NUM_AXES-1:0]  clr_pulse;  // faulted bits being cleared

    assign chan0_wr  = wr.wen && (wr.chan == '0);
    assign status_wr = chan0_wr && (wr.off == qla_pkg::OFF_STATUS);
    assign dout_wr   = chan0_wr && (wr.off == qla_pkg::OFF_DOUT);

    // one cycle pulse, only where a fault is actually latched
    assign clr_pulse = status_wr ? (wr.data[qla_pkg::NUM_AXES-1:0] & fault) : '0;

    always_comb begin
        for (int a = 0; a < qla_pkg::NUM_AXES; a++) begin
            cmd_wr[a] = wr.wen && (wr.chan == qla_pkg::chan_t'(a + 1)) &&
                        (wr.off == qla_pkg::OFF_DAC_CTRL);
        end
    end

    always_ff @(posedge sysclk) begin
        state.cur_fb <= cur_fb;                    // 1 cycle feedback latch

        if (!rst_n) begin
            state.cur_cmd <= qla_pkg::CMD_RST;     // midscale, no current
            state.amp_req <= '0;
            dout          <= '0;
        end else begin
            for (int a = 0; a < qla_pkg::NUM_AXES; a++) begin
                if (cmd_wr[a])
                    state.cur_cmd[a] <= wr.data[qla_pkg::CUR_W-1:0];
            end
            if (status_wr)
                state.amp_req <= wr.data[qla_pkg::NUM_AXES-1:0];   // also re-arms
            if (dout_wr)
                dout <= wr.data[3:0];
        end
    end

    assign cur_cmd = state.cur_cmd;                // parallel DAC words

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    for (genvar a = 0; a < qla_pkg::NUM_AXES; a++) begin : g_cmd_chk
        ap_cmd_own: assert property (@(posedge sysclk) disable iff (!rst_n)
            !$stable(state.cur_cmd[a]) |-> $past(cmd_wr[a]))
            else $error("DAC command %0d changed without its own write", a + 1);
    end

    // safety_check must drop each cleared fault on the next edge
    ap_fault_clr: assert property (@(posedge sysclk) disable iff (!rst_n)
        (|clr_pulse) |=> ((fault & $past(clr_pulse)) == '0))
        else $error("status write did not clear the latched fault");

endmodule

`default_nettype wire

/* hdl/qla_pkg.sv */
// shared widths, register map and stage structs for the axis control core
// register address: [15:12] space, [7:4] channel, [3:0] offset
// channel 0 is the board channel, channels 1..NUM_AXES are the motor axes
// current words are offset binary, midscale means zero current
`default_nettype none

package qla_pkg;

    // ------------------------------------------------------------------------
    // bus and field widths
    // ------------------------------------------------------------------------
    localparam int NUM_AXES = 4;
    localparam int ADDR_W   = 16;
    localparam int DATA_W   = 32;
    localparam int CHAN_W   = 4;               // address bits 7:4
    localparam int OFF_W    = 4;               // address bits 3:0
    localparam int CUR_W    = 16;

    typedef logic [CHAN_W-1:0] chan_t;
    typedef logic [OFF_W-1:0]  off_t;
    typedef logic [CUR_W-1:0]  cur_t;
    typedef cur_t [NUM_AXES-1:0] cur_vec_t;    // axis 1 sits in element 0

    // ------------------------------------------------------------------------
    // register map
    // ------------------------------------------------------------------------
    localparam logic [3:0] SPACE_MAIN = 4'h0;  // only space kept

    // axis channels
    localparam off_t OFF_ADC_DATA = 4'd0;      // latched current feedback
    localparam off_t OFF_DAC_CTRL = 4'd1;      // current command

    // board channel
    localparam off_t OFF_STATUS   = 4'd0;      // amp_req, faults, board id
    localparam off_t OFF_DOUT     = 4'd1;      // digital outputs

    // reset values
    localparam cur_t     CUR_MID = 16'h8000;
    localparam cur_vec_t CMD_RST = {NUM_AXES{CUR_MID}};   // all axes at zero current

    // ------------------------------------------------------------------------
    // stage structs
    // ------------------------------------------------------------------------
    // decoded write, 41 bits
    typedef struct packed {
        logic              wen;                // set only for main space writes
        chan_t             chan;
        off_t              off;
        logic [DATA_W-1:0] data;
    } reg_wr_t;

    // decoded read, 9 bits
    typedef struct packed {
        logic  in_space;                       // low reads back 0
        chan_t chan;
        off_t  off;
    } reg_rd_t;

    // per-axis state out of the register file, 132 bits
    typedef struct packed {
        cur_vec_t            cur_cmd;
        cur_vec_t            cur_fb;
        logic [NUM_AXES-1:0] amp_req;          // host enable request
    } axis_state_t;

endpackage

`default_nettype wire

/* hdl/qla_top.sv */
// axis control core top, decode -> register file -> safety check
// read mux sits beside the register file
// writes visible 2 cycles after reg_wen, reads return 2 cycles after address
`timescale 1ns/1ns
`default_nettype none

module qla_top #(
    parameter int unsigned SAFETY_CYCLES = 8,      // consecutive over cycles to fault
    parameter int unsigned SAFETY_MARGIN = 16      // added to twice command magnitude
) (
    input  wire logic                              sysclk,
    input  wire logic                              rst_n,
    input  wire logic                              reg_wen,
    input  wire logic [qla_pkg::ADDR_W-1:0]        reg_waddr,
    input  wire logic [qla_pkg::DATA_W-1:0]        reg_wdata,
    input  wire logic [qla_pkg::ADDR_W-1:0]        reg_raddr,
    output logic [qla_pkg::DATA_W-1:0]             reg_rdata,
    input  wire logic [3:0]                        board_id,    // rotary switch
    input  qla_pkg::cur_vec_t                      cur_fb,      // parallel ADC words
    output qla_pkg::cur_vec_t                      cur_cmd,     // parallel DAC words
    output logic [qla_pkg::NUM_AXES-1:0]           amp_enable,
    output logic [3:0]                             dout
);

    // ------------------------------------------------------------------------
    // stage wires
    // ------------------------------------------------------------------------
    qla_pkg::reg_wr_t              wr;
    qla_pkg::reg_rd_t              rd;
    qla_pkg::axis_state_t          state;
    logic [qla_pkg::NUM_AXES-1:0]  fault;

    reg_decode u_decode (
        .sysclk(sysclk), .rst_n(rst_n),
        .reg_wen(reg_wen), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_raddr(reg_raddr), .wr(wr), .rd(rd)
    );

    axis_regs u_regs (
        .sysclk(sysclk), .rst_n(rst_n), .wr(wr), .cur_fb(cur_fb), .fault(fault),
        .state(state), .cur_cmd(cur_cmd), .dout(dout)
    );

    safety_check #(.SAFETY_CYCLES(SAFETY_CYCLES), .SAFETY_MARGIN(SAFETY_MARGIN)) u_safety (
        .sysclk(sysclk), .rst_n(rst_n), .state(state), .wr(wr),
        .fault(fault), .amp_enable(amp_enable)
    );

    read_mux u_rmux (
        .sysclk(sysclk), .rst_n(rst_n), .rd(rd), .state(state), .fault(fault),
        .dout(dout), .board_id(board_id), .reg_rdata(reg_rdata)
    );

endmodule

`default_nettype wire

/* hdl/read_mux.sv */
// read data select by channel and offset, registered
// reg_rdata follows reg_raddr two cycles later
// anything unmapped or outside the main space reads 0
`timescale 1ns/1ns
`default_nettype none

module read_mux (
    input  wire logic                              sysclk,
    input  wire logic                              rst_n,
    input  qla_pkg::reg_rd_t                       rd,
    input  qla_pkg::axis_state_t                   state,
    input  wire logic [qla_pkg::NUM_AXES-1:0]      fault,
    input  wire logic [3:0]                        dout,
    input  wire logic [3:0]                        board_id,
    output logic [qla_pkg::DATA_W-1:0]             reg_rdata
);

    localparam int PAD_W = qla_pkg::DATA_W - qla_pkg::CUR_W;

    logic [qla_pkg::DATA_W-1:0] rdata_nxt;

    always_comb begin
        rdata_nxt = '0;
        if (rd.in_space) begin
            // board channel
            if (rd.chan == '0) begin
                case (rd.off)
                    qla_pkg::OFF_STATUS:
                        rdata_nxt = {4'd0, board_id, 16'd0, fault, state.amp_req};
                    qla_pkg::OFF_DOUT:
                        rdata_nxt = {28'd0, dout};
                    default: ;
                endcase
            end
            // motor axes 1..NUM_AXES
            for (int a = 0; a < qla_pkg::NUM_AXES; a++) begin
                if (rd.chan == qla_pkg::chan_t'(a + 1)) begin
                    case (rd.off)
                        qla_pkg::OFF_ADC_DATA: rdata_nxt = {{PAD_W{1'b0}}, state.cur_fb[a]};
                        qla_pkg::OFF_DAC_CTRL: rdata_nxt = {{PAD_W{1'b0}}, state.cur_cmd[a]};
                        default: ;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n)
            reg_rdata <= '0;
        else
            reg_rdata <= rdata_nxt;                // second read stage
    end

endmodule

`default_nettype wire

/* hdl/reg_decode.sv */
// first stage, registers the host bus request
// the space test lives only here, later stages trust wen and in_space
// reg_wen is a single cycle strobe, no stall and no handshake
// address bits 11:8 are ignored
`timescale 1ns/1ns
`default_nettype none

module reg_decode (
    input  wire logic                          sysclk,
    input  wire logic                          rst_n,
    input  wire logic                          reg_wen,
    input  wire logic [qla_pkg::ADDR_W-1:0]    reg_waddr,
    input  wire logic [qla_pkg::DATA_W-1:0]    reg_wdata,
    input  wire logic [qla_pkg::ADDR_W-1:0]    reg_raddr,
    output qla_pkg::reg_wr_t                   wr,
    output qla_pkg::reg_rd_t                   rd
);

    logic w_in_space;                          // write hits main space
    logic r_in_space;                          // read hits main space

    assign w_in_space = (reg_waddr[qla_pkg::ADDR_W-1 -: 4] == qla_pkg::SPACE_MAIN);
    assign r_in_space = (reg_raddr[qla_pkg::ADDR_W-1 -: 4] == qla_pkg::SPACE_MAIN);

    always_ff @(posedge sysclk) begin
        // payload, follows the bus every cycle
        wr.chan <= reg_waddr[qla_pkg::OFF_W +: qla_pkg::CHAN_W];
        wr.off  <= reg_waddr[qla_pkg::OFF_W-1:0];
        wr.data <= reg_wdata;
        rd.chan <= reg_raddr[qla_pkg::OFF_W +: qla_pkg::CHAN_W];
        rd.off  <= reg_raddr[qla_pkg::OFF_W-1:0];

        if (!rst_n) begin
            wr.wen      <= 1'b0;
            rd.in_space <= 1'b0;
        end else begin
            wr.wen      <= reg_wen & w_in_space;   // masked strobe
            rd.in_space <= r_in_space;
        end
    end

    // a write to a foreign space must never reach the register file
    ap_space_mask: assert property (@(posedge sysclk) disable iff (!rst_n)
        (reg_wen && !w_in_space) |=> !wr.wen)
        else $error("write strobe passed for a write outside the main space");

endmodule

`default_nettype wire

/* hdl/safety_check.sv */
// over-current guard, feedback magnitude against twice command plus margin
// magnitudes are distances from midscale, sign is ignored
// needs SAFETY_CYCLES >= 1, fault latches on the Nth consecutive cycle
// only a status write with the axis bit set clears a fault
`timescale 1ns/1ns
`default_nettype none

module safety_check #(
    parameter int unsigned SAFETY_CYCLES = 8,
    parameter int unsigned SAFETY_MARGIN = 16
) (
    input  wire logic                              sysclk,
    input  wire logic                              rst_n,
    input  qla_pkg::axis_state_t                   state,
    input  qla_pkg::reg_wr_t                       wr,
    output logic [qla_pkg::NUM_AXES-1:0]           fault,
    output logic [qla_pkg::NUM_AXES-1:0]           amp_enable
);

    localparam int CNT_W = $clog2(SAFETY_CYCLES + 1);
    localparam int BND_W = qla_pkg::CUR_W + 2;     // 2*mag + margin headroom

    logic                          status_wr;
    logic [qla_pkg::NUM_AXES-1:0]  clr;            // host fault clear
    logic [qla_pkg::NUM_AXES-1:0]  over;           // over-current this cycle
    logic [qla_pkg::NUM_AXES-1:0]  fault_nxt;
    logic [CNT_W-1:0]              cnt [qla_pkg::NUM_AXES];   // consecutive over cycles

    // distance from midscale
    function automatic qla_pkg::cur_t cur_mag(input qla_pkg::cur_t c);
        cur_mag = (c >= qla_pkg::CUR_MID) ? (c - qla_pkg::CUR_MID) : (qla_pkg::CUR_MID - c);
    endfunction

    assign status_wr = wr.wen && (wr.chan == '0) && (wr.off == qla_pkg::OFF_STATUS);
    assign clr       = status_wr ? wr.data[qla_pkg::NUM_AXES-1:0] : '0;

    // ------------------------------------------------------------------------
    // compare and fault set
    // ------------------------------------------------------------------------
    always_comb begin
        for (int a = 0; a < qla_pkg::NUM_AXES; a++) begin
            over[a] = {2'b00, cur_mag(state.cur_fb[a])} >
                      ({1'b0, cur_mag(state.cur_cmd[a]), 1'b0} + BND_W'(SAFETY_MARGIN));
            // clear wins over a set in the same cycle
            fault_nxt[a] = clr[a] ? 1'b0 :
                           (fault[a] | (over[a] && (cnt[a] == CNT_W'(SAFETY_CYCLES - 1))));
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            fault      <= '0;
            amp_enable <= '0;
            for (int a = 0; a < qla_pkg::NUM_AXES; a++)
                cnt[a] <= '0;
        end else begin
            fault      <= fault_nxt;
            amp_enable <= state.amp_req & ~fault_nxt;  // drops on the fault edge
            for (int a = 0; a < qla_pkg::NUM_AXES; a++) begin
                if (clr[a] || !over[a])
                    cnt[a] <= '0;                       // restart filter
                else if (cnt[a] != CNT_W'(SAFETY_CYCLES - 1))
                    cnt[a] <= cnt[a] + 1'b1;            // saturates
            end
        end
    end

    // enable needs a prior request from the register file and no fault
    for (genvar a = 0; a < qla_pkg::NUM_AXES; a++) begin : g_amp_chk
        ap_amp_safe: assert property (@(posedge sysclk) disable iff (!rst_n)
            amp_enable[a] |-> (!fault[a] && $past(state.amp_req[a])))
            else $error("amp_enable %0d high while faulted or not requested", a + 1);
    end

endmodule

`default_nettype wire

/* verif/tb_qla.sv */
// random-stimulus testbench for qla_top, LCG seeded with 32'h297a7818
// model tracks DAC commands, amp_req, dout and faults from the register rules
// inputs change on the rising edge, outputs are sampled on the falling edge
// feedback is kept within the over-current bound except on the faulted axis
`timescale 1ns/1ns
`default_nettype none

module tb_qla;

    localparam int unsigned SAFETY_CYCLES = 8;
    localparam int unsigned SAFETY_MARGIN = 16;
    localparam int          NAX = qla_pkg::NUM_AXES;

    logic               sysclk;
    logic               rst_n;
    logic               reg_wen;
    logic [15:0]        reg_waddr;
    logic [31:0]        reg_wdata;
    logic [15:0]        reg_raddr;
    logic [31:0]        reg_rdata;
    logic [3:0]         board_id;
    qla_pkg::cur_vec_t  cur_fb;
    qla_pkg::cur_vec_t  cur_cmd;
    logic [3:0]         amp_enable;
    logic [3:0]         dout;

    // model state
    qla_pkg::cur_vec_t  m_cmd;
    qla_pkg::cur_vec_t  m_fb;
    logic [3:0]         m_amp_req;
    logic [3:0]         m_dout;
    logic [3:0]         m_fault;
    int                 errors;
    int                 timeouts;
    logic [31:0]        rng;

    qla_top #(.SAFETY_CYCLES(SAFETY_CYCLES), .SAFETY_MARGIN(SAFETY_MARGIN)) DUT (
        .sysclk(sysclk), .rst_n(rst_n), .reg_wen(reg_wen), .reg_waddr(reg_waddr),
        .reg_wdata(reg_wdata), .reg_raddr(reg_raddr), .reg_rdata(reg_rdata),
        .board_id(board_id), .cur_fb(cur_fb), .cur_cmd(cur_cmd),
        .amp_enable(amp_enable), .dout(dout)
    );

    always #20 sysclk = ~sysclk;                   // 40 ns period

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;  // numerical recipes LCG
        return rng;
    endfunction

    function automatic logic [15:0] addr_of(input logic [3:0] chan, input logic [3:0] off);
        return {qla_pkg::SPACE_MAIN, 4'h0, chan, off};
    endfunction

    // distance from midscale
    function automatic int unsigned magnitude(input logic [15:0] c);
        if (c >= qla_pkg::CUR_MID)
            return 32'(c - qla_pkg::CUR_MID);
        return 32'(qla_pkg::CUR_MID - c);
    endfunction

    function automatic int unsigned fb_bound(input logic [15:0] cmd);
        return 2 * magnitude(cmd) + SAFETY_MARGIN;   // largest allowed fb magnitude
    endfunction

    function automatic logic [15:0] fb_from_mag(input int unsigned m, input logic neg);
        if (neg)
            return qla_pkg::CUR_MID - m[15:0];
        return qla_pkg::CUR_MID + m[15:0];
    endfunction

    function automatic logic [31:0] status_word();
        return {4'd0, board_id, 16'd0, m_fault, m_amp_req};
    endfunction

    // register rules as the host sees them
    function automatic void model_write(input logic [15:0] addr, input logic [31:0] data);
        int ch;
        ch = int'(addr[7:4]);
        if (addr[15:12] != qla_pkg::SPACE_MAIN)
            return;                                // foreign space, ignored
        if (ch == 0 && addr[3:0] == qla_pkg::OFF_STATUS) begin
            m_amp_req = data[3:0];
            m_fault   = m_fault & ~data[3:0];      // status write clears faults
        end else if (ch == 0 && addr[3:0] == qla_pkg::OFF_DOUT) begin
            m_dout = data[3:0];
        end else if (ch >= 1 && ch <= NAX && addr[3:0] == qla_pkg::OFF_DAC_CTRL) begin
            m_cmd[ch - 1] = data[15:0];
        end
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("ERROR %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // one-cycle strobe, returns once amp_enable has caught up
    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        @(posedge sysclk);
        reg_wen   <= 1'b1;
        reg_waddr <= addr;
        reg_wdata <= data;
        @(posedge sysclk);
        reg_wen <= 1'b0;
        @(posedge sysclk);
        @(posedge sysclk);
        model_write(addr, data);
    endtask

    task automatic expect_read(input logic [15:0] addr, input logic [31:0] exp,
                               input string what);
        @(posedge sysclk);
        reg_raddr <= addr;
        @(posedge sysclk);
        @(posedge sysclk);                         // two-cycle read latency
        @(negedge sysclk);
        check_value(what, reg_rdata, exp);
    endtask

    task automatic set_fb(input qla_pkg::cur_vec_t v);
        @(posedge sysclk);
        cur_fb <= v;
        m_fb = v;
    endtask

    task automatic check_outputs();
        @(negedge sysclk);
        check_value("amp_enable", {28'd0, amp_enable}, {28'd0, m_amp_req & ~m_fault});
        check_value("dout", {28'd0, dout}, {28'd0, m_dout});
        for (int a = 0; a < NAX; a++)
            check_value($sformatf("cur_cmd axis %0d", a + 1), {16'd0, cur_cmd[a]},
                        {16'd0, m_cmd[a]});
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0]       r;
        logic [3:0]        sp;
        qla_pkg::cur_vec_t v;
        int                ax;
        int                n;
        int unsigned       m;

        rng       = 32'h297a7818;
        errors    = 0;
        timeouts  = 0;
        sysclk    = 1'b0;
        rst_n     = 1'b0;
        reg_wen   = 1'b0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_raddr = '0;
        r         = next_rand();
        board_id  = r[27:24];
        cur_fb    = qla_pkg::CMD_RST;
        m_fb      = qla_pkg::CMD_RST;
        m_cmd     = qla_pkg::CMD_RST;
        m_amp_req = '0;
        m_dout    = '0;
        m_fault   = '0;

        for (int i = 0; i < 16; i++)
            @(posedge sysclk);
        rst_n <= 1'b1;

        // reset state
        check_outputs();
        expect_read(addr_of(4'd0, qla_pkg::OFF_STATUS), status_word(), "status after reset");

        // DAC commands, fb sits at midscale so nothing can fault
        for (int i = 0; i < 12; i++) begin
            r  = next_rand();
            ax = int'(r[9:8]);
            write_reg(addr_of(4'(ax + 1), qla_pkg::OFF_DAC_CTRL), next_rand());
            check_outputs();
            expect_read(addr_of(4'(ax + 1), qla_pkg::OFF_DAC_CTRL), {16'd0, m_cmd[ax]},
                        $sformatf("DAC readback axis %0d", ax + 1));
        end
        for (int i = 0; i < 4; i++) begin
            r  = next_rand();
            sp = (r[15:12] == 4'h0) ? 4'h1 : r[15:12];   // any space but main
            write_reg({sp, 4'h0, 4'(r[1:0] + 2'd1), qla_pkg::OFF_DAC_CTRL}, next_rand());
            check_outputs();
            expect_read({sp, 4'h0, 4'(r[1:0] + 2'd1), qla_pkg::OFF_DAC_CTRL}, 32'd0,
                        "read outside main space");
        end

        // feedback within bounds, then unmapped space
        for (int i = 0; i < 4; i++) begin
            for (int a = 0; a < NAX; a++) begin
                r = next_rand();
                m = r % (fb_bound(m_cmd[a]) + 1);
                if (m > 32767)
                    m = 32767;
                v[a] = fb_from_mag(m, r[31]);
            end
            set_fb(v);
            for (int a = 0; a < NAX; a++)
                expect_read(addr_of(4'(a + 1), qla_pkg::OFF_ADC_DATA), {16'd0, m_fb[a]},
                            $sformatf("ADC readback axis %0d", a + 1));
            r = next_rand();
            expect_read(addr_of(4'(r % 5), 4'(2 + r[15:8] % 14)), 32'd0, "unmapped offset");
            expect_read(addr_of(4'(5 + r[23:16] % 11), r[27:24]), 32'd0, "unmapped channel");
        end

        // enables and digital outputs
        for (int i = 0; i < 6; i++) begin
            r = next_rand();
            write_reg(addr_of(4'd0, qla_pkg::OFF_STATUS), {28'd0, r[7:4]});
            write_reg(addr_of(4'd0, qla_pkg::OFF_DOUT), {28'd0, r[11:8]});
            check_outputs();
            expect_read(addr_of(4'd0, qla_pkg::OFF_STATUS), status_word(), "status word");
            expect_read(addr_of(4'd0, qla_pkg::OFF_DOUT), {28'd0, m_dout}, "dout word");
        end

        // ------------------------------------------------------------------------
        // over current on one axis
        // ------------------------------------------------------------------------
        set_fb(qla_pkg::CMD_RST);
        write_reg(addr_of(4'd0, qla_pkg::OFF_STATUS), 32'h0000_000f);
        r  = next_rand();
        ax = int'(r[1:0]);
        write_reg(addr_of(4'(ax + 1), qla_pkg::OFF_DAC_CTRL),
                  {16'd0, fb_from_mag(r % 4096, r[31])});   // small cmd leaves headroom
        check_outputs();
        v     = qla_pkg::CMD_RST;
        v[ax] = fb_from_mag(fb_bound(m_cmd[ax]) + 1 + (next_rand() % 64), r[30]);
        set_fb(v);
        for (n = 0; n < int'(SAFETY_CYCLES) + 4 && amp_enable[ax]; n++)
            @(negedge sysclk);
        if (amp_enable[ax]) begin
            timeouts++;
            $display("timeout: amp_enable of axis %0d stayed high under over-current", ax + 1);
        end
        for (; n <= int'(SAFETY_CYCLES) + 4; n++)
            @(negedge sysclk);                     // keep holding past the filter
        m_fault[ax] = 1'b1;
        check_outputs();
        expect_read(addr_of(4'd0, qla_pkg::OFF_STATUS), status_word(), "status with fault");

        // back within bounds, then the host clears the fault
        set_fb(qla_pkg::CMD_RST);
        @(posedge sysclk);
        @(posedge sysclk);
        write_reg(addr_of(4'd0, qla_pkg::OFF_STATUS), 32'h0000_000f);
        check_outputs();
        expect_read(addr_of(4'd0, qla_pkg::OFF_STATUS), status_word(), "status after clear");

        $display("errors=%0d timeouts=%0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
